//--- source/csr_pkg.sv
package csr_pkg;

	// csr numbers
	localparam logic [13:0] CSR_CRMD    = 14'h000;
	localparam logic [13:0] CSR_ASID    = 14'h018;
	localparam logic [13:0] CSR_TLBIDX  = 14'h010;
	localparam logic [13:0] CSR_TLBEHI  = 14'h011;
	localparam logic [13:0] CSR_TLBELO0 = 14'h012;
	localparam logic [13:0] CSR_TLBELO1 = 14'h013;
	localparam logic [13:0] CSR_DMW0    = 14'h180;
	localparam logic [13:0] CSR_DMW1    = 14'h181;

	// writable bits
	localparam logic [31:0] ASID_MASK   = 32'h0000_03FF;
	localparam logic [31:0] TLBIDX_MASK = 32'hBF00_000F;
	localparam logic [31:0] TLBEHI_MASK = 32'hFFFF_E000;
	localparam logic [31:0] TLBELO_MASK = 32'h0FFF_FF7F;

	// field positions
	localparam int TLBIDX_NE   = 31;
	localparam int TLBIDX_PS   = 24;
	localparam int TLBEHI_VPPN = 13;
	localparam int TLBELO_V    = 0;
	localparam int TLBELO_D    = 1;
	localparam int TLBELO_PLV  = 2;
	localparam int TLBELO_MAT  = 4;
	localparam int TLBELO_G    = 6;
	localparam int TLBELO_PPN  = 8;

	// invtlb op field
	localparam logic [4:0] INVTLB_ALL     = 5'd0;
	localparam logic [4:0] INVTLB_ASID_VA = 5'd5;

	typedef enum logic [2:0] {
		TLBOP_WR   = 3'd0,
		TLBOP_FILL = 3'd1,
		TLBOP_RD   = 3'd2,
		TLBOP_INV  = 3'd3
	} tlb_op_e;

	typedef struct packed {
		logic [22:0] rsv;
		logic [1:0]  datm;
		logic [1:0]  datf;
		logic        pg;
		logic        da;
		logic        ie;
		logic [1:0]  plv;
	} crmd_view_t;

	typedef struct packed {
		logic [2:0]  vseg;
		logic        rsv0;
		logic [2:0]  pseg;
		logic [18:0] rsv1;
		logic [1:0]  mat;
		logic        plv3;
		logic [1:0]  rsv2;
		logic        plv0;
	} dmw_view_t;

	typedef union packed {
		logic [31:0] w;
		crmd_view_t  crmd;
		dmw_view_t   dmw;
	} csr_word_u;

endpackage

//--- source/mmu_pkg.sv
package mmu_pkg;

	localparam int TLB_ENTRIES = 16;
	localparam int TLB_IDX_W   = 4;
	localparam int VPPN_W      = 19;
	localparam int PPN_W       = 20;
	localparam int ASID_W      = 10;

	// 4 KiB pages only
	localparam logic [5:0] PS_4K = 6'd12;

	typedef struct packed {
		logic [PPN_W-1:0] ppn;
		logic [1:0]       plv;
		logic [1:0]       mat;
		logic             d;
		logic             v;
	} tlb_half_t;

	typedef struct packed {
		logic              e;
		logic [VPPN_W-1:0] vppn;
		logic [5:0]        ps;
		logic              g;
		logic [ASID_W-1:0] asid;
		tlb_half_t         p0;
		tlb_half_t         p1;
	} tlb_entry_t;

	typedef enum logic [5:0] {
		ECODE_NONE = 6'h00,
		ECODE_PIL  = 6'h01,
		ECODE_PIS  = 6'h02,
		ECODE_PIF  = 6'h03,
		ECODE_PME  = 6'h04,
		ECODE_PPI  = 6'h07,
		ECODE_TLBR = 6'h3F
	} xlate_ecode_e;

	typedef struct packed {
		logic [31:0]  paddr;
		xlate_ecode_e ecode;
	} xlate_result_t;

endpackage

//--- source/csr_view_if.sv
interface csr_view_if;
	import csr_pkg::*;
	import mmu_pkg::*;

	logic [1:0]        plv;
	logic              da;
	logic              pg;
	logic [ASID_W-1:0] asid;
	csr_word_u         dmw0;
	csr_word_u         dmw1;
	logic [31:0]       tlbehi;
	logic [31:0]       tlbelo0;
	logic [31:0]       tlbelo1;
	logic [31:0]       tlbidx;

	modport src(output plv, da, pg, asid, dmw0, dmw1, tlbehi, tlbelo0, tlbelo1, tlbidx);
	modport snk(input plv, da, pg, asid, dmw0, dmw1, tlbehi, tlbelo0, tlbelo1, tlbidx);

endinterface

//--- source/tlb_search_if.sv
interface tlb_search_if;
	import mmu_pkg::*;

	// request side
	logic [VPPN_W-1:0] vppn;
	logic              odd;
	logic [ASID_W-1:0] asid;

	// matched half, same cycle
	logic              hit;
	logic [PPN_W-1:0]  ppn;
	logic [1:0]        plv;
	logic [1:0]        mat;
	logic              v;
	logic              d;

	modport req(output vppn, odd, asid, input hit, ppn, plv, mat, v, d);
	modport rsp(input vppn, odd, asid, output hit, ppn, plv, mat, v, d);

endinterface

//--- source/csr_xlate_regs.sv
module csr_xlate_regs (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                csr_we_i,
	input  logic [13:0]         csr_addr_i,
	input  csr_pkg::csr_word_u  csr_wdata_i,
	output logic [31:0]         csr_rdata_o,
	input  logic                tlbrd_valid_i,
	input  mmu_pkg::tlb_entry_t tlbrd_entry_i,
	input  logic                tlbrd_hit_i,
	csr_view_if.src             view
);
	import csr_pkg::*;
	import mmu_pkg::*;

	csr_word_u   crmd_q, dmw0_q, dmw1_q;
	logic [31:0] asid_q, tlbidx_q, tlbehi_q, tlbelo0_q, tlbelo1_q;
	csr_word_u   crmd_wr, dmw_wr;

	function automatic logic [31:0] half_to_elo(input tlb_half_t h, input logic g);
		logic [31:0] w;
		w = '0;
		w[TLBELO_V] = h.v;
		w[TLBELO_D] = h.d;
		w[TLBELO_PLV +: 2] = h.plv;
		w[TLBELO_MAT +: 2] = h.mat;
		w[TLBELO_G] = g;
		w[TLBELO_PPN +: PPN_W] = h.ppn;
		return w;
	endfunction

	// write data through the two views, reserved bits dropped
	always_comb begin
		crmd_wr = '0;
		crmd_wr.crmd.plv = csr_wdata_i.crmd.plv;
		crmd_wr.crmd.ie = csr_wdata_i.crmd.ie;
		crmd_wr.crmd.da = csr_wdata_i.crmd.da;
		// DA takes priority when both are requested
		crmd_wr.crmd.pg = csr_wdata_i.crmd.pg & ~csr_wdata_i.crmd.da;
		crmd_wr.crmd.datf = csr_wdata_i.crmd.datf;
		crmd_wr.crmd.datm = csr_wdata_i.crmd.datm;
		dmw_wr = '0;
		dmw_wr.dmw.plv0 = csr_wdata_i.dmw.plv0;
		dmw_wr.dmw.plv3 = csr_wdata_i.dmw.plv3;
		dmw_wr.dmw.mat = csr_wdata_i.dmw.mat;
		dmw_wr.dmw.pseg = csr_wdata_i.dmw.pseg;
		dmw_wr.dmw.vseg = csr_wdata_i.dmw.vseg;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			crmd_q <= '0;
			crmd_q.crmd.da <= 1'b1;
			dmw0_q <= '0;
			dmw1_q <= '0;
			asid_q <= '0;
			tlbidx_q <= '0;
			tlbehi_q <= '0;
			tlbelo0_q <= '0;
			tlbelo1_q <= '0;
		end else begin
			if (csr_we_i) begin
				case (csr_addr_i)
					CSR_CRMD:    crmd_q <= crmd_wr;
					CSR_DMW0:    dmw0_q <= dmw_wr;
					CSR_DMW1:    dmw1_q <= dmw_wr;
					CSR_ASID:    asid_q <= csr_wdata_i.w & ASID_MASK;
					CSR_TLBIDX:  tlbidx_q <= csr_wdata_i.w & TLBIDX_MASK;
					CSR_TLBEHI:  tlbehi_q <= csr_wdata_i.w & TLBEHI_MASK;
					CSR_TLBELO0: tlbelo0_q <= csr_wdata_i.w & TLBELO_MASK;
					CSR_TLBELO1: tlbelo1_q <= csr_wdata_i.w & TLBELO_MASK;
					default: ;
				endcase
			end
			// tlbrd overrides a software write in the same cycle
			if (tlbrd_valid_i) begin
				tlbidx_q[TLBIDX_NE] <= ~tlbrd_hit_i;
				if (tlbrd_hit_i) begin
					tlbidx_q[TLBIDX_PS +: 6] <= tlbrd_entry_i.ps;
					tlbehi_q <= {tlbrd_entry_i.vppn, {TLBEHI_VPPN{1'b0}}};
					tlbelo0_q <= half_to_elo(tlbrd_entry_i.p0, tlbrd_entry_i.g);
					tlbelo1_q <= half_to_elo(tlbrd_entry_i.p1, tlbrd_entry_i.g);
					asid_q[ASID_W-1:0] <= tlbrd_entry_i.asid;
				end else begin
					tlbidx_q[TLBIDX_PS +: 6] <= '0;
					tlbehi_q <= '0;
					tlbelo0_q <= '0;
					tlbelo1_q <= '0;
					asid_q[ASID_W-1:0] <= '0;
				end
			end
		end
	end

	always_comb begin
		case (csr_addr_i)
			CSR_CRMD:    csr_rdata_o = crmd_q.w;
			CSR_DMW0:    csr_rdata_o = dmw0_q.w;
			CSR_DMW1:    csr_rdata_o = dmw1_q.w;
			CSR_ASID:    csr_rdata_o = asid_q;
			CSR_TLBIDX:  csr_rdata_o = tlbidx_q;
			CSR_TLBEHI:  csr_rdata_o = tlbehi_q;
			CSR_TLBELO0: csr_rdata_o = tlbelo0_q;
			CSR_TLBELO1: csr_rdata_o = tlbelo1_q;
			default:     csr_rdata_o = '0;
		endcase
	end

	assign view.plv = crmd_q.crmd.plv;
	assign view.da = crmd_q.crmd.da;
	assign view.pg = crmd_q.crmd.pg;
	assign view.asid = asid_q[ASID_W-1:0];
	assign view.dmw0 = dmw0_q;
	assign view.dmw1 = dmw1_q;
	assign view.tlbehi = tlbehi_q;
	assign view.tlbelo0 = tlbelo0_q;
	assign view.tlbelo1 = tlbelo1_q;
	assign view.tlbidx = tlbidx_q;

	// translation mode is never ambiguous for the ports
	a_da_pg_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(view.da && view.pg));

endmodule

//--- source/tlb.sv
module tlb (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        op_valid_i,
	input  csr_pkg::tlb_op_e            op_i,
	input  logic [4:0]                  invtlb_op_i,
	input  logic [mmu_pkg::ASID_W-1:0]  invtlb_asid_i,
	input  logic [31:0]                 invtlb_va_i,
	csr_view_if.snk                     view,
	tlb_search_if.rsp                   fetch_s,
	tlb_search_if.rsp                   data_s,
	output logic                        tlbrd_valid_o,
	output mmu_pkg::tlb_entry_t         tlbrd_entry_o,
	output logic                        tlbrd_hit_o
);
	import csr_pkg::*;
	import mmu_pkg::*;

	tlb_entry_t             ent_q [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] valid_q;
	logic [TLB_IDX_W-1:0]   fill_cnt_q;
	logic [TLB_IDX_W-1:0]   wr_idx, rd_idx;
	tlb_entry_t             wr_ent;
	logic                   wr_en;
	logic [TLB_ENTRIES-1:0] fetch_m, data_m;
	tlb_half_t              fetch_h, data_h;

	function automatic tlb_half_t elo_half(input logic [31:0] w);
		tlb_half_t h;
		h.ppn = w[TLBELO_PPN +: PPN_W];
		h.plv = w[TLBELO_PLV +: 2];
		h.mat = w[TLBELO_MAT +: 2];
		h.d = w[TLBELO_D];
		h.v = w[TLBELO_V];
		return h;
	endfunction

	function automatic logic [TLB_ENTRIES-1:0] match(input logic [VPPN_W-1:0] vppn,
			input logic [ASID_W-1:0] asid);
		logic [TLB_ENTRIES-1:0] m;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			m[i] = valid_q[i] && ent_q[i].vppn == vppn && (ent_q[i].g || ent_q[i].asid == asid);
		end
		return m;
	endfunction

	// one-hot match, so an OR is enough
	function automatic tlb_half_t pick(input logic [TLB_ENTRIES-1:0] m, input logic odd);
		tlb_half_t h;
		h = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (m[i]) begin
				h = h | (odd ? ent_q[i].p1 : ent_q[i].p0);
			end
		end
		return h;
	endfunction

	always_comb begin
		fetch_m = match(fetch_s.vppn, fetch_s.asid);
		data_m = match(data_s.vppn, data_s.asid);
		fetch_h = pick(fetch_m, fetch_s.odd);
		data_h = pick(data_m, data_s.odd);
	end

	assign fetch_s.hit = |fetch_m;
	assign fetch_s.ppn = fetch_h.ppn;
	assign fetch_s.plv = fetch_h.plv;
	assign fetch_s.mat = fetch_h.mat;
	assign fetch_s.v = fetch_h.v;
	assign fetch_s.d = fetch_h.d;
	assign data_s.hit = |data_m;
	assign data_s.ppn = data_h.ppn;
	assign data_s.plv = data_h.plv;
	assign data_s.mat = data_h.mat;
	assign data_s.v = data_h.v;
	assign data_s.d = data_h.d;

	// write entry straight from the csr words
	always_comb begin
		wr_ent.e = ~view.tlbidx[TLBIDX_NE];
		wr_ent.vppn = view.tlbehi[TLBEHI_VPPN +: VPPN_W];
		wr_ent.ps = PS_4K;
		wr_ent.g = view.tlbelo0[TLBELO_G] & view.tlbelo1[TLBELO_G];
		wr_ent.asid = view.asid;
		wr_ent.p0 = elo_half(view.tlbelo0);
		wr_ent.p1 = elo_half(view.tlbelo1);
	end

	assign rd_idx = view.tlbidx[TLB_IDX_W-1:0];
	assign wr_idx = (op_i == TLBOP_FILL) ? fill_cnt_q : rd_idx;
	assign wr_en = op_valid_i && (op_i == TLBOP_WR || op_i == TLBOP_FILL);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			ent_q[wr_idx] <= wr_ent;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			fill_cnt_q <= '0;
		end else begin
			fill_cnt_q <= fill_cnt_q + 1'b1;
			if (wr_en) begin
				valid_q[wr_idx] <= wr_ent.e;
			end else if (op_valid_i && op_i == TLBOP_INV) begin
				if (invtlb_op_i == INVTLB_ALL) begin
					valid_q <= '0;
				end else if (invtlb_op_i == INVTLB_ASID_VA) begin
					for (int i = 0; i < TLB_ENTRIES; i++) begin
						if (!ent_q[i].g && ent_q[i].asid == invtlb_asid_i &&
								ent_q[i].vppn == invtlb_va_i[31:TLBEHI_VPPN]) begin
							valid_q[i] <= 1'b0;
						end
					end
				end
			end
		end
	end

	always_comb begin
		tlbrd_entry_o = ent_q[rd_idx];
		tlbrd_entry_o.e = valid_q[rd_idx];
	end

	assign tlbrd_valid_o = op_valid_i && op_i == TLBOP_RD;
	assign tlbrd_hit_o = valid_q[rd_idx];

	// duplicate entries would make the port result ambiguous
	a_onehot_match: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(fetch_m) && $onehot0(data_m));

endmodule

//--- source/addr_xlate.sv
module addr_xlate (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  stall_i,
	input  logic                  req_i,
	input  logic [31:0]           vaddr_i,
	input  logic                  store_i,
	input  logic                  fetch_i,
	csr_view_if.snk               view,
	tlb_search_if.req             s,
	output logic                  valid_o,
	output logic [31:0]           paddr_o,
	output mmu_pkg::xlate_ecode_e ecode_o
);
	import csr_pkg::*;
	import mmu_pkg::*;

	xlate_result_t res, result_q;
	logic          valid_q;
	logic          dmw0_hit, dmw1_hit;

	function automatic logic dmw_hit(input csr_word_u w, input logic [1:0] plv,
			input logic [2:0] seg);
		return ((w.dmw.plv0 && plv == 2'd0) || (w.dmw.plv3 && plv == 2'd3)) && w.dmw.vseg == seg;
	endfunction

	assign s.vppn = vaddr_i[31:32-VPPN_W];
	assign s.odd = vaddr_i[12];
	assign s.asid = view.asid;

	assign dmw0_hit = dmw_hit(view.dmw0, view.plv, vaddr_i[31:29]);
	assign dmw1_hit = dmw_hit(view.dmw1, view.plv, vaddr_i[31:29]);

	always_comb begin
		res.paddr = vaddr_i;
		res.ecode = ECODE_NONE;
		if (view.da || !view.pg) begin
			res.paddr = vaddr_i;
		end else if (dmw0_hit) begin
			res.paddr = {view.dmw0.dmw.pseg, vaddr_i[28:0]};
		end else if (dmw1_hit) begin
			res.paddr = {view.dmw1.dmw.pseg, vaddr_i[28:0]};
		end else begin
			res.paddr = {s.ppn, vaddr_i[11:0]};
			// tlb checks in priority order
			if (!s.hit) begin
				res.ecode = ECODE_TLBR;
			end else if (!s.v) begin
				if (fetch_i) begin
					res.ecode = ECODE_PIF;
				end else if (store_i) begin
					res.ecode = ECODE_PIS;
				end else begin
					res.ecode = ECODE_PIL;
				end
			end else if (view.plv > s.plv) begin
				res.ecode = ECODE_PPI;
			end else if (store_i && !s.d) begin
				res.ecode = ECODE_PME;
			end
		end
		if (res.ecode != ECODE_NONE) begin
			res.paddr = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (!stall_i) begin
			valid_q <= req_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i && req_i) begin
			result_q <= res;
		end
	end

	assign valid_o = valid_q;
	assign paddr_o = result_q.paddr;
	assign ecode_o = result_q.ecode;

	// a stalled port only holds, it never starts a new response
	a_no_rise_after_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(stall_i) |-> !$rose(valid_o));

endmodule

//--- source/mmu_top.sv
module mmu_top (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       csr_we_i,
	input  logic [13:0]                csr_addr_i,
	input  logic [31:0]                csr_wdata_i,
	output logic [31:0]                csr_rdata_o,
	input  logic                       tlb_op_valid_i,
	input  csr_pkg::tlb_op_e           tlb_op_i,
	input  logic [4:0]                 invtlb_op_i,
	input  logic [mmu_pkg::ASID_W-1:0] invtlb_asid_i,
	input  logic [31:0]                invtlb_va_i,
	input  logic                       fetch_req_i,
	input  logic [31:0]                fetch_vaddr_i,
	output logic                       fetch_valid_o,
	output logic [31:0]                fetch_paddr_o,
	output mmu_pkg::xlate_ecode_e      fetch_ecode_o,
	input  logic                       data_req_i,
	input  logic [31:0]                data_vaddr_i,
	input  logic                       data_store_i,
	output logic                       data_valid_o,
	output logic [31:0]                data_paddr_o,
	output mmu_pkg::xlate_ecode_e      data_ecode_o,
	input  logic                       stall_i
);
	import mmu_pkg::*;

	csr_view_if   view();
	tlb_search_if fetch_s();
	tlb_search_if data_s();

	logic       tlbrd_valid;
	logic       tlbrd_hit;
	tlb_entry_t tlbrd_entry;

	csr_xlate_regs csr_regs (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.csr_we_i(csr_we_i),
		.csr_addr_i(csr_addr_i),
		.csr_wdata_i(csr_wdata_i),
		.csr_rdata_o(csr_rdata_o),
		.tlbrd_valid_i(tlbrd_valid),
		.tlbrd_entry_i(tlbrd_entry),
		.tlbrd_hit_i(tlbrd_hit),
		.view(view.src)
	);

	tlb tlb_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.op_valid_i(tlb_op_valid_i),
		.op_i(tlb_op_i),
		.invtlb_op_i(invtlb_op_i),
		.invtlb_asid_i(invtlb_asid_i),
		.invtlb_va_i(invtlb_va_i),
		.view(view.snk),
		.fetch_s(fetch_s.rsp),
		.data_s(data_s.rsp),
		.tlbrd_valid_o(tlbrd_valid),
		.tlbrd_entry_o(tlbrd_entry),
		.tlbrd_hit_o(tlbrd_hit)
	);

	// fetch side never stores
	addr_xlate xlate_fetch (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall_i),
		.req_i(fetch_req_i),
		.vaddr_i(fetch_vaddr_i),
		.store_i(1'b0),
		.fetch_i(1'b1),
		.view(view.snk),
		.s(fetch_s.req),
		.valid_o(fetch_valid_o),
		.paddr_o(fetch_paddr_o),
		.ecode_o(fetch_ecode_o)
	);

	addr_xlate xlate_data (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall_i),
		.req_i(data_req_i),
		.vaddr_i(data_vaddr_i),
		.store_i(data_store_i),
		.fetch_i(1'b0),
		.view(view.snk),
		.s(data_s.req),
		.valid_o(data_valid_o),
		.paddr_o(data_paddr_o),
		.ecode_o(data_ecode_o)
	);

endmodule

//--- bench/mmu_checker.sv
module mmu_checker (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  string                      test_name,
	input  logic                       csr_we_i,
	input  logic [13:0]                csr_addr_i,
	input  logic [31:0]                csr_wdata_i,
	input  logic [31:0]                csr_rdata_o,
	input  logic                       tlb_op_valid_i,
	input  csr_pkg::tlb_op_e           tlb_op_i,
	input  logic [4:0]                 invtlb_op_i,
	input  logic [mmu_pkg::ASID_W-1:0] invtlb_asid_i,
	input  logic [31:0]                invtlb_va_i,
	input  logic                       fetch_req_i,
	input  logic [31:0]                fetch_vaddr_i,
	input  logic                       fetch_valid_o,
	input  logic [31:0]                fetch_paddr_o,
	input  mmu_pkg::xlate_ecode_e      fetch_ecode_o,
	input  logic                       data_req_i,
	input  logic [31:0]                data_vaddr_i,
	input  logic                       data_store_i,
	input  logic                       data_valid_o,
	input  logic [31:0]                data_paddr_o,
	input  mmu_pkg::xlate_ecode_e      data_ecode_o,
	input  logic                       stall_i,
	output int                         err_cnt,
	output int                         chk_cnt
);
	import csr_pkg::*;
	import mmu_pkg::*;

	logic [31:0] m_crmd, m_asid, m_tlbidx, m_ehi, m_elo0, m_elo1, m_dmw0, m_dmw1;
	logic        t_valid [16];
	logic [18:0] t_vppn [16];
	logic        t_g [16];
	logic [9:0]  t_asid [16];
	logic [31:0] t_elo0 [16];
	logic [31:0] t_elo1 [16];
	logic [3:0]  m_fill;
	logic        f_ev, d_ev;
	logic [31:0] f_ep, d_ep;
	logic [5:0]  f_ee, d_ee;

	function automatic logic [31:0] read_csr(input logic [13:0] a);
		case (a)
			CSR_CRMD:    return m_crmd;
			CSR_ASID:    return m_asid;
			CSR_TLBIDX:  return m_tlbidx;
			CSR_TLBEHI:  return m_ehi;
			CSR_TLBELO0: return m_elo0;
			CSR_TLBELO1: return m_elo1;
			CSR_DMW0:    return m_dmw0;
			CSR_DMW1:    return m_dmw1;
			default:     return 32'h0;
		endcase
	endfunction

	function automatic logic window(input logic [31:0] w, input logic [1:0] plv,
			input logic [31:0] va);
		csr_word_u u;
		u.w = w;
		return ((u.dmw.plv0 && plv == 2'd0) || (u.dmw.plv3 && plv == 2'd3)) &&
			u.dmw.vseg == va[31:29];
	endfunction

	function automatic void predict(input logic [31:0] va, input logic fetch, input logic store,
			output logic [31:0] pa, output logic [5:0] ec);
		csr_word_u   c, w0, w1;
		int          hit_i;
		logic [31:0] elo;
		c.w = m_crmd;
		w0.w = m_dmw0;
		w1.w = m_dmw1;
		pa = va;
		ec = ECODE_NONE;
		hit_i = -1;
		if (c.crmd.da || !c.crmd.pg) begin
			return;
		end
		if (window(m_dmw0, c.crmd.plv, va)) begin
			pa = {w0.dmw.pseg, va[28:0]};
			return;
		end
		if (window(m_dmw1, c.crmd.plv, va)) begin
			pa = {w1.dmw.pseg, va[28:0]};
			return;
		end
		for (int i = 0; i < 16; i++) begin
			if (t_valid[i] && t_vppn[i] == va[31:13] && (t_g[i] || t_asid[i] == m_asid[9:0]))
				hit_i = i;
		end
		if (hit_i < 0) begin
			ec = ECODE_TLBR;
		end else begin
			elo = va[12] ? t_elo1[hit_i] : t_elo0[hit_i];
			if (!elo[0])
				ec = fetch ? ECODE_PIF : (store ? ECODE_PIS : ECODE_PIL);
			else if (c.crmd.plv > elo[3:2])
				ec = ECODE_PPI;
			else if (store && !elo[1])
				ec = ECODE_PME;
			else
				pa = {elo[27:8], va[11:0]};
		end
		if (ec != ECODE_NONE) begin
			pa = 32'h0;
		end
	endfunction

	task automatic check_port(input string port, input logic ev, input logic [31:0] ep,
			input logic [5:0] ee, input logic av, input logic [31:0] ap, input logic [5:0] ae);
		if (av !== ev) begin
			err_cnt++;
			$display("[ERROR] %0s %0s valid expected %0b actual %0b", test_name, port, ev, av);
		end else if (ev) begin
			chk_cnt++;
			if (ap !== ep || ae !== ee) begin
				err_cnt++;
				$display("[ERROR] %0s %0s expected paddr %h ecode %h actual paddr %h ecode %h",
					test_name, port, ep, ee, ap, ae);
			end
		end
	endtask

	task automatic write_entry(input logic [3:0] i);
		logic g;
		g = m_elo0[6] & m_elo1[6];
		t_valid[i] = ~m_tlbidx[31];
		t_vppn[i] = m_ehi[31:13];
		t_g[i] = g;
		t_asid[i] = m_asid[9:0];
		t_elo0[i] = {m_elo0[31:7], g, m_elo0[5:0]};
		t_elo1[i] = {m_elo1[31:7], g, m_elo1[5:0]};
	endtask

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
	end

	always @(posedge clk or negedge rst_n_i) begin
		csr_word_u  w, r;
		logic [3:0] idx;
		logic       rd;
		if (!rst_n_i) begin
			m_crmd = 32'h8;
			{m_asid, m_tlbidx, m_ehi, m_elo0, m_elo1, m_dmw0, m_dmw1} = '0;
			for (int i = 0; i < 16; i++)
				t_valid[i] = 1'b0;
			m_fill = 4'd0;
			f_ev = 1'b0;
			d_ev = 1'b0;
		end else begin
			// outputs still show the previous edge here
			check_port("fetch", f_ev, f_ep, f_ee, fetch_valid_o, fetch_paddr_o, fetch_ecode_o);
			check_port("data", d_ev, d_ep, d_ee, data_valid_o, data_paddr_o, data_ecode_o);
			chk_cnt++;
			if (csr_rdata_o !== read_csr(csr_addr_i)) begin
				err_cnt++;
				$display("[ERROR] %0s csr %h expected %h actual %h", test_name, csr_addr_i,
					read_csr(csr_addr_i), csr_rdata_o);
			end
			if (!stall_i) begin
				f_ev = fetch_req_i;
				d_ev = data_req_i;
				if (fetch_req_i)
					predict(fetch_vaddr_i, 1'b1, 1'b0, f_ep, f_ee);
				if (data_req_i)
					predict(data_vaddr_i, 1'b0, data_store_i, d_ep, d_ee);
			end
			idx = m_tlbidx[3:0];
			rd = tlb_op_valid_i && tlb_op_i == TLBOP_RD;
			if (tlb_op_valid_i && tlb_op_i == TLBOP_WR)
				write_entry(idx);
			if (tlb_op_valid_i && tlb_op_i == TLBOP_FILL)
				write_entry(m_fill);
			if (tlb_op_valid_i && tlb_op_i == TLBOP_INV) begin
				for (int i = 0; i < 16; i++) begin
					if (invtlb_op_i == 5'd0 || (invtlb_op_i == 5'd5 && !t_g[i] &&
							t_asid[i] == invtlb_asid_i && t_vppn[i] == invtlb_va_i[31:13]))
						t_valid[i] = 1'b0;
				end
			end
			if (csr_we_i) begin
				w.w = csr_wdata_i;
				r.w = '0;
				case (csr_addr_i)
					CSR_CRMD: begin
						r.crmd.plv = w.crmd.plv;
						r.crmd.ie = w.crmd.ie;
						r.crmd.da = w.crmd.da;
						r.crmd.pg = w.crmd.pg & ~w.crmd.da;
						r.crmd.datf = w.crmd.datf;
						r.crmd.datm = w.crmd.datm;
						m_crmd = r.w;
					end
					CSR_DMW0, CSR_DMW1: begin
						r.dmw.plv0 = w.dmw.plv0;
						r.dmw.plv3 = w.dmw.plv3;
						r.dmw.mat = w.dmw.mat;
						r.dmw.pseg = w.dmw.pseg;
						r.dmw.vseg = w.dmw.vseg;
						if (csr_addr_i == CSR_DMW0)
							m_dmw0 = r.w;
						else
							m_dmw1 = r.w;
					end
					CSR_ASID:    m_asid = csr_wdata_i & 32'h0000_03FF;
					CSR_TLBIDX:  m_tlbidx = csr_wdata_i & 32'hBF00_000F;
					CSR_TLBEHI:  m_ehi = csr_wdata_i & 32'hFFFF_E000;
					CSR_TLBELO0: m_elo0 = csr_wdata_i & 32'h0FFF_FF7F;
					CSR_TLBELO1: m_elo1 = csr_wdata_i & 32'h0FFF_FF7F;
					default: ;
				endcase
			end
			// a tlbrd wins over a software write
			if (rd) begin
				m_tlbidx[31] = ~t_valid[idx];
				m_tlbidx[29:24] = t_valid[idx] ? 6'd12 : 6'd0;
				m_ehi = t_valid[idx] ? {t_vppn[idx], 13'h0} : 32'h0;
				m_elo0 = t_valid[idx] ? t_elo0[idx] : 32'h0;
				m_elo1 = t_valid[idx] ? t_elo1[idx] : 32'h0;
				m_asid[9:0] = t_valid[idx] ? t_asid[idx] : 10'h0;
			end
			m_fill = m_fill + 4'd1;
		end
	end

endmodule

//--- bench/tb_mmu.sv
module tb_mmu;
	import csr_pkg::*;
	import mmu_pkg::*;

	logic              clk, rst_n_i;
	logic              csr_we_i;
	logic [13:0]       csr_addr_i;
	logic [31:0]       csr_wdata_i, csr_rdata_o;
	logic              tlb_op_valid_i;
	tlb_op_e           tlb_op_i;
	logic [4:0]        invtlb_op_i;
	logic [ASID_W-1:0] invtlb_asid_i;
	logic [31:0]       invtlb_va_i;
	logic              fetch_req_i, fetch_valid_o, data_req_i, data_store_i, data_valid_o;
	logic [31:0]       fetch_vaddr_i, fetch_paddr_o, data_vaddr_i, data_paddr_o;
	xlate_ecode_e      fetch_ecode_o, data_ecode_o;
	logic              stall_i;
	string             test_name;
	int                err_cnt, chk_cnt, err_start, chk_start, timeouts, tests_run;
	logic [31:0]       seed, r, d0, d1;
	logic [18:0]       vppn_tab [16];
	logic [9:0]        asid_tab [16];

	mmu_top DUT (.*);

	mmu_checker chk (.*);

	always #10 clk = ~clk;

	// two lcg steps give the upper halves
	function automatic logic [31:0] lcg_next();
		logic [15:0] hi;
		seed = seed * 32'd1103515245 + 32'd12345;
		hi = seed[31:16];
		seed = seed * 32'd1103515245 + 32'd12345;
		return {hi, seed[31:16]};
	endfunction

	function automatic logic [13:0] csr_sel(input logic [2:0] i);
		case (i)
			3'd0: return CSR_CRMD;
			3'd1: return CSR_ASID;
			3'd2: return CSR_TLBIDX;
			3'd3: return CSR_TLBEHI;
			3'd4: return CSR_TLBELO0;
			3'd5: return CSR_TLBELO1;
			3'd6: return CSR_DMW0;
			default: return CSR_DMW1;
		endcase
	endfunction

	task automatic csr_write(input logic [13:0] a, input logic [31:0] d);
		csr_we_i = 1'b1;
		csr_addr_i = a;
		csr_wdata_i = d;
		@(negedge clk);
		csr_we_i = 1'b0;
	endtask

	task automatic tlb_cmd(input tlb_op_e op, input logic [4:0] iop, input logic [9:0] as,
			input logic [31:0] va);
		tlb_op_valid_i = 1'b1;
		tlb_op_i = op;
		invtlb_op_i = iop;
		invtlb_asid_i = as;
		invtlb_va_i = va;
		@(negedge clk);
		tlb_op_valid_i = 1'b0;
	endtask

	task automatic read_back();
		for (int i = 0; i < 8; i++) begin
			csr_addr_i = csr_sel(i[2:0]);
			@(negedge clk);
		end
	endtask

	task automatic access(input logic fe, input logic [31:0] fva, input logic de,
			input logic [31:0] dva, input logic st, input logic stalls);
		int n;
		fetch_req_i = fe;
		fetch_vaddr_i = fva;
		data_req_i = de;
		data_vaddr_i = dva;
		data_store_i = st;
		// request held through a few random stall cycles
		n = 0;
		do begin
			r = lcg_next();
			stall_i = stalls && r[0] && n < 8;
			@(negedge clk);
			n++;
		end while (stall_i);
		fetch_req_i = 1'b0;
		data_req_i = 1'b0;
		r = lcg_next();
		// hold the answer for a cycle now and then
		stall_i = stalls && r[1];
		n = 0;
		while (((fe && !fetch_valid_o) || (de && !data_valid_o)) && n < 10) begin
			@(negedge clk);
			n++;
		end
		if ((fe && !fetch_valid_o) || (de && !data_valid_o)) begin
			$display("%0s port never answered", (fe && !fetch_valid_o) ? "fetch" : "data");
			timeouts++;
		end
		@(negedge clk);
		stall_i = 1'b0;
	endtask

	function automatic logic [31:0] paged_va();
		logic [31:0] a, b;
		a = lcg_next();
		b = lcg_next();
		if (a[9:8] == 2'd0)
			return b;
		return {vppn_tab[a[3:0]], b[12:0]};
	endfunction

	task automatic run_accesses(input int n, input logic stalls);
		logic [31:0] c;
		for (int i = 0; i < n; i++) begin
			c = lcg_next();
			access(c[0] | c[1], paged_va(), ~c[0] | stalls, paged_va(), c[2], stalls);
		end
	endtask

	task automatic write_table();
		for (int i = 0; i < 16; i++) begin
			r = lcg_next();
			asid_tab[i] = {9'h0, r[20]};
			vppn_tab[i] = {r[14:0], i[3:0]};
			csr_write(CSR_ASID, {22'h0, asid_tab[i]});
			csr_write(CSR_TLBIDX, {r[31:29] == 3'd0, 27'h0, i[3:0]});
			csr_write(CSR_TLBEHI, {vppn_tab[i], 13'h0});
			csr_write(CSR_TLBELO0, lcg_next());
			csr_write(CSR_TLBELO1, lcg_next());
			tlb_cmd(TLBOP_WR, 5'd0, 10'h0, 32'h0);
		end
	endtask

	task automatic start_test(input string nm);
		test_name = nm;
		err_start = err_cnt;
		chk_start = chk_cnt;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %0s finished: %0d checks, %0d errors", test_name,
			chk_cnt - chk_start, err_cnt - err_start);
	endtask

	initial begin
		seed = 32'd4;
		clk = 1'b0;
		rst_n_i = 1'b0;
		{csr_we_i, tlb_op_valid_i, fetch_req_i, data_req_i, data_store_i, stall_i} = '0;
		csr_addr_i = CSR_CRMD;
		csr_wdata_i = '0;
		tlb_op_i = TLBOP_WR;
		invtlb_op_i = '0;
		invtlb_asid_i = '0;
		{invtlb_va_i, fetch_vaddr_i, data_vaddr_i} = '0;
		test_name = "reset";
		timeouts = 0;
		tests_run = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);

		start_test("csr_rw");
		for (int i = 0; i < 48; i++) begin
			r = lcg_next();
			csr_write(csr_sel(r[2:0]), lcg_next());
		end
		read_back();
		end_test();

		start_test("direct_dmw");
		csr_write(CSR_CRMD, 32'h8);
		run_accesses(8, 1'b0);
		for (int k = 0; k < 6; k++) begin
			r = lcg_next();
			d0 = lcg_next();
			d1 = lcg_next();
			csr_write(CSR_CRMD, {27'h0, 1'b1, 2'b00, r[1:0]});
			csr_write(CSR_DMW0, d0);
			csr_write(CSR_DMW1, k[0] ? {d0[31:29], d1[28:0]} : d1);
			for (int i = 0; i < 6; i++) begin
				r = lcg_next();
				access(1'b1, {r[0] ? d0[31:29] : d1[31:29], r[31:3]}, 1'b1,
					{r[1] ? d0[31:29] : d1[31:29], r[28:0]}, r[2], 1'b0);
			end
		end
		end_test();

		start_test("tlbwr_paged");
		csr_write(CSR_DMW0, 32'h0);
		csr_write(CSR_DMW1, 32'h0);
		write_table();
		for (int k = 0; k < 6; k++) begin
			r = lcg_next();
			csr_write(CSR_CRMD, {27'h0, 1'b1, 2'b00, r[1:0]});
			csr_write(CSR_ASID, {31'h0, r[5]});
			run_accesses(8, 1'b0);
		end
		end_test();

		start_test("fill_rd");
		tlb_cmd(TLBOP_INV, 5'd0, 10'h0, 32'h0);
		for (int k = 0; k < 16; k++) begin
			r = lcg_next();
			vppn_tab[k] = {r[14:0], k[3:0]};
			csr_write(CSR_TLBIDX, 32'h0);
			csr_write(CSR_TLBEHI, {vppn_tab[k], 13'h0});
			csr_write(CSR_TLBELO0, lcg_next());
			csr_write(CSR_TLBELO1, lcg_next());
			repeat (r[17:16]) @(negedge clk);
			tlb_cmd(TLBOP_FILL, 5'd0, 10'h0, 32'h0);
		end
		for (int i = 0; i < 16; i++) begin
			csr_write(CSR_TLBIDX, {28'h0, i[3:0]});
			tlb_cmd(TLBOP_RD, 5'd0, 10'h0, 32'h0);
			read_back();
		end
		run_accesses(16, 1'b0);
		end_test();

		start_test("invtlb");
		write_table();
		run_accesses(12, 1'b0);
		for (int k = 0; k < 6; k++) begin
			r = lcg_next();
			tlb_cmd(TLBOP_INV, 5'd5, asid_tab[r[3:0]], {vppn_tab[r[3:0]], 13'h0});
			run_accesses(4, 1'b0);
		end
		tlb_cmd(TLBOP_INV, 5'd0, 10'h0, 32'h0);
		run_accesses(8, 1'b0);
		end_test();

		start_test("stall_dual");
		write_table();
		run_accesses(40, 1'b1);
		end_test();

		$display("tests %0d, checks %0d, errors %0d, timeouts %0d", tests_run, chk_cnt,
			err_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
source/csr_pkg.sv
source/mmu_pkg.sv
source/csr_view_if.sv
source/tlb_search_if.sv
source/csr_xlate_regs.sv
source/tlb.sv
source/addr_xlate.sv
source/mmu_top.sv
bench/mmu_checker.sv
bench/tb_mmu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
